//--- hc_consts.svh
/* hybrid controller constants
   data widths, reset gains, trig scale and timing limits */
`ifndef HC_CONSTS_SVH
`define HC_CONSTS_SVH

// --------------------------------------
// data widths
// --------------------------------------
`define HC_SAMPLE_W   14      // adc samples, signed
`define HC_ANGLE_W    32      // angles in integer degrees, signed
`define HC_COEF_W     32      // gain registers
`define HC_ACC_W      48      // surface accumulator
`define HC_TRIG_W     16      // sine / cosine words
`define HC_AXI_AW     5       // axi4-lite byte address
`define HC_AXI_DW     32      // axi4-lite data

// --------------------------------------
// reset gains and scaling
// --------------------------------------
`define HC_MU_Z1_RST  86
`define HC_MU_Z2_RST  90
`define HC_MU_VG_RST  312000
`define HC_TRIG_ONE   16384   // sin(90) in table units

// timing
`define HC_DB_LEN     4       // cycles a condition must differ before it passes
`define HC_MIN_DWELL  8       // cycles in a state before the next jump

`endif

//--- hc_ctrl_pkg.sv
/* switching automaton types
   state encoding with its sigma and mosfet decode */
package hc_ctrl_pkg;

   // state value doubles as index of the selected jump condition
   typedef enum logic [1:0] {
      ST_POS    = 2'd0,   // sigma +1, watches c1
      ST_ZERO_A = 2'd1,   // sigma 0, watches c2
      ST_NEG    = 2'd2,   // sigma -1, watches c3
      ST_ZERO_B = 2'd3    // sigma 0, watches c4
   } sw_state_e;

   typedef logic signed [1:0] sigma_t;

   localparam sigma_t SIGMA_POS  = 2'sb01;
   localparam sigma_t SIGMA_ZERO = 2'sb00;
   localparam sigma_t SIGMA_NEG  = 2'sb11;

   // gate patterns, bit 3 down to bit 0
   localparam logic [3:0] MOS_POS  = 4'b1001;
   localparam logic [3:0] MOS_ZERO = 4'b0011;   // freewheel, both zero states
   localparam logic [3:0] MOS_NEG  = 4'b0110;

   function automatic sigma_t state_sigma(input sw_state_e st);
      case (st)
         ST_POS:  return SIGMA_POS;
         ST_NEG:  return SIGMA_NEG;
         default: return SIGMA_ZERO;
      endcase
   endfunction

   function automatic logic [3:0] state_mosfet(input sw_state_e st);
      case (st)
         ST_POS:  return MOS_POS;
         ST_NEG:  return MOS_NEG;
         default: return MOS_ZERO;
      endcase
   endfunction

endpackage

//--- hc_regs_pkg.sv
/* axi4-lite register map of the hybrid controller */
`include "hc_consts.svh"

package hc_regs_pkg;

   typedef enum logic [`HC_AXI_AW-1:0] {
      REG_CTRL   = 5'h00,   // bit 0 run
      REG_MU_Z1  = 5'h04,
      REG_MU_Z2  = 5'h08,
      REG_MU_VG  = 5'h0C,
      REG_THETA  = 5'h10,   // degrees
      REG_PHI    = 5'h14,   // degrees
      REG_STATUS = 5'h18    // read only, [1:0] state [3:2] sigma
   } reg_addr_e;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- hc_coef_if.sv
/* configuration bundle from register bank to datapath */
`timescale 1ns/1ps
`include "hc_consts.svh"

interface hc_coef_if;

   logic signed [`HC_COEF_W-1:0]  mu_z1;   // vc gain
   logic signed [`HC_COEF_W-1:0]  mu_z2;   // ic gain
   logic signed [`HC_COEF_W-1:0]  mu_vg;   // sigma offset gain
   logic signed [`HC_ANGLE_W-1:0] theta;   // frequency angle
   logic signed [`HC_ANGLE_W-1:0] phi;     // phase angle
   logic                          run;

   // register bank owns everything
   modport regs (output mu_z1, mu_z2, mu_vg, theta, phi, run);

   // datapath only needs gains and angles
   modport eval (input mu_z1, mu_z2, mu_vg, theta, phi);

endinterface

//--- hc_trig_lut.sv
/* sine and cosine of an integer degree angle
   5 degree quarter-wave table, cosine via 90 degree offset */
`timescale 1ns/1ps
`include "hc_consts.svh"

module hc_trig_lut (
   input  logic signed [`HC_ANGLE_W-1:0] i_angle,   // any range, degrees
   output logic signed [`HC_TRIG_W-1:0]  o_sin,
   output logic signed [`HC_TRIG_W-1:0]  o_cos
);

   localparam int TW = `HC_TRIG_W;

   // sin(5k) scaled by trig one, k = 0..18
   localparam logic signed [TW-1:0] SIN_TAB [19] = '{
      16'sd0,     16'sd1428,  16'sd2845,  16'sd4240,  16'sd5604,
      16'sd6924,  16'sd8192,  16'sd9397,  16'sd10531, 16'sd11585,
      16'sd12551, 16'sd13421, 16'sd14189, 16'sd14849, 16'sd15396,
      16'sd15826, 16'sd16135, 16'sd16322, TW'(`HC_TRIG_ONE)
   };

   logic signed [`HC_ANGLE_W-1:0] ang_rem;   // -359..359
   logic [8:0]                    ang_deg;   // 0..359
   logic [6:0]                    idx_s;     // 5 degree step, 0..71
   logic [6:0]                    idx_c;

   // fold into first quadrant, then fix sign
   function automatic logic signed [TW-1:0] lookup(input logic [6:0] idx);
      logic [1:0]           quad;
      logic [4:0]           pos;
      logic signed [TW-1:0] mag;
      quad = 2'(idx / 7'd18);
      pos  = 5'(idx % 7'd18);
      mag  = SIN_TAB[quad[0] ? 5'd18 - pos : pos];   // mirrored in q1, q3
      return quad[1] ? -mag : mag;                   // negative half
   endfunction

   assign ang_rem = i_angle % 360;
   assign ang_deg = 9'(ang_rem < 0 ? ang_rem + 360 : ang_rem);
   assign idx_s   = 7'(ang_deg / 9'd5);   // quantize down
   assign idx_c   = (idx_s >= 7'd54) ? idx_s - 7'd54 : idx_s + 7'd18;

   assign o_sin = lookup(idx_s);
   assign o_cos = lookup(idx_c);

endmodule

//--- hc_axil_regs.sv
/* axi4-lite slave register bank
   holds run, gains and angles, returns automaton status */
`timescale 1ns/1ps
`include "hc_consts.svh"

module hc_axil_regs (
   input  logic                   i_clock,
   input  logic                   i_RESET,
   input  logic [`HC_AXI_AW-1:0]  i_awaddr,
   input  logic                   i_awvalid,
   output logic                   o_awready,
   input  logic [`HC_AXI_DW-1:0]  i_wdata,
   input  logic [3:0]             i_wstrb,
   input  logic                   i_wvalid,
   output logic                   o_wready,
   output logic [1:0]             o_bresp,
   output logic                   o_bvalid,
   input  logic                   i_bready,
   input  logic [`HC_AXI_AW-1:0]  i_araddr,
   input  logic                   i_arvalid,
   output logic                   o_arready,
   output logic [`HC_AXI_DW-1:0]  o_rdata,
   output logic [1:0]             o_rresp,
   output logic                   o_rvalid,
   input  logic                   i_rready,
   input  hc_ctrl_pkg::sw_state_e i_state,
   hc_coef_if.regs                coef
);

   logic                  wr_go;   // aw and w handshake together
   logic                  rd_go;
   logic [`HC_AXI_DW-1:0] status;

   // byte lane merge
   function automatic logic [31:0] merge(input logic [31:0] old_v,
                                         input logic [31:0] new_v,
                                         input logic [3:0]  strb);
      logic [31:0] res;
      res = old_v;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) res[8*b +: 8] = new_v[8*b +: 8];
      end
      return res;
   endfunction

   assign wr_go     = i_awvalid & i_wvalid & ~o_bvalid;   // one write in flight
   assign o_awready = wr_go;
   assign o_wready  = wr_go;
   assign rd_go     = i_arvalid & ~o_rvalid;
   assign o_arready = rd_go;

   assign status = {28'd0, hc_ctrl_pkg::state_sigma(i_state), i_state};

   // --------------------------------------
   // write channel
   // --------------------------------------
   always_ff @(posedge i_clock or negedge i_RESET) begin
      if (!i_RESET) begin
         o_bvalid   <= 1'b0;
         o_bresp    <= hc_regs_pkg::RESP_OKAY;
         coef.run   <= 1'b0;
         coef.mu_z1 <= `HC_MU_Z1_RST;
         coef.mu_z2 <= `HC_MU_Z2_RST;
         coef.mu_vg <= `HC_MU_VG_RST;
         coef.theta <= '0;
         coef.phi   <= '0;
      end else begin
         if (o_bvalid && i_bready) o_bvalid <= 1'b0;
         if (wr_go) begin
            o_bvalid <= 1'b1;   // response next cycle
            o_bresp  <= hc_regs_pkg::RESP_OKAY;
            case (hc_regs_pkg::reg_addr_e'(i_awaddr))
               hc_regs_pkg::REG_CTRL:   if (i_wstrb[0]) coef.run <= i_wdata[0];
               hc_regs_pkg::REG_MU_Z1:  coef.mu_z1 <= merge(coef.mu_z1, i_wdata, i_wstrb);
               hc_regs_pkg::REG_MU_Z2:  coef.mu_z2 <= merge(coef.mu_z2, i_wdata, i_wstrb);
               hc_regs_pkg::REG_MU_VG:  coef.mu_vg <= merge(coef.mu_vg, i_wdata, i_wstrb);
               hc_regs_pkg::REG_THETA:  coef.theta <= merge(coef.theta, i_wdata, i_wstrb);
               hc_regs_pkg::REG_PHI:    coef.phi   <= merge(coef.phi, i_wdata, i_wstrb);
               hc_regs_pkg::REG_STATUS: ;   // read only, write dropped
               default:                 o_bresp <= hc_regs_pkg::RESP_SLVERR;
            endcase
         end
      end
   end

   // --------------------------------------
   // read channel
   // --------------------------------------
   always_ff @(posedge i_clock or negedge i_RESET) begin
      if (!i_RESET) begin
         o_rvalid <= 1'b0;
         o_rresp  <= hc_regs_pkg::RESP_OKAY;
         o_rdata  <= '0;
      end else begin
         if (o_rvalid && i_rready) o_rvalid <= 1'b0;
         if (rd_go) begin
            o_rvalid <= 1'b1;
            o_rresp  <= hc_regs_pkg::RESP_OKAY;
            case (hc_regs_pkg::reg_addr_e'(i_araddr))
               hc_regs_pkg::REG_CTRL:   o_rdata <= {31'd0, coef.run};
               hc_regs_pkg::REG_MU_Z1:  o_rdata <= coef.mu_z1;
               hc_regs_pkg::REG_MU_Z2:  o_rdata <= coef.mu_z2;
               hc_regs_pkg::REG_MU_VG:  o_rdata <= coef.mu_vg;
               hc_regs_pkg::REG_THETA:  o_rdata <= coef.theta;
               hc_regs_pkg::REG_PHI:    o_rdata <= coef.phi;
               hc_regs_pkg::REG_STATUS: o_rdata <= status;
               default: begin
                  o_rdata <= '0;
                  o_rresp <= hc_regs_pkg::RESP_SLVERR;
               end
            endcase
         end
      end
   end

endmodule

//--- hc_jump_eval.sv
/* jump surface evaluation, three register stages
   samples to normalized coordinates to the four raw jump conditions */
`timescale 1ns/1ps
`include "hc_consts.svh"

module hc_jump_eval (
   input  logic                           i_clock,
   input  logic                           i_RESET,
   input  logic signed [`HC_SAMPLE_W-1:0] i_vc,
   input  logic signed [`HC_SAMPLE_W-1:0] i_ic,
   input  hc_ctrl_pkg::sw_state_e         i_state,
   hc_coef_if.eval                        coef,
   output logic [3:0]                     o_cond   // {c4, c3, c2, c1}
);

   localparam int ACC = `HC_ACC_W;
   localparam int TW  = `HC_TRIG_W;
   localparam int TSH = $clog2(`HC_TRIG_ONE);   // divide by trig one

   logic signed [`HC_ANGLE_W-1:0] ang_p, ang_m;
   logic signed [TW-1:0]  sp_c, cp_c, sm_c, cm_c;   // table outputs
   logic signed [ACC-1:0] vg_term, z1_c, z2_c;
   // stage 1
   logic signed [TW-1:0]  sp_q, cp_q, sm_q, cm_q;
   logic signed [ACC-1:0] z1_q, z2_q, vg_q;
   // stage 2
   logic signed [ACC-1:0] z1sm_q, z2cm_q, z1sp_q, z2cp_q, c_q;
   // stage 3 sums
   logic signed [ACC-1:0] s1, s2, s3;

   assign ang_p = coef.theta + coef.phi;
   assign ang_m = coef.theta - coef.phi;

   hc_trig_lut u_trig_p (.i_angle(ang_p), .o_sin(sp_c), .o_cos(cp_c));
   hc_trig_lut u_trig_m (.i_angle(ang_m), .o_sin(sm_c), .o_cos(cm_c));

   // z1 = mu_z1 vc - sigma mu_vg, sigma from current state
   assign vg_term = ACC'(hc_ctrl_pkg::state_sigma(i_state)) * ACC'(coef.mu_vg);
   assign z1_c    = ACC'(coef.mu_z1) * ACC'(i_vc) - vg_term;
   assign z2_c    = ACC'(coef.mu_z2) * ACC'(i_ic);

   // surfaces, products already scaled back
   assign s1 = z1sm_q + z2cm_q + c_q;
   assign s2 = z1sp_q + z2cp_q;
   assign s3 = z1sm_q + z2cm_q - c_q;

   always_ff @(posedge i_clock or negedge i_RESET) begin
      if (!i_RESET) begin
         {sp_q, cp_q, sm_q, cm_q} <= '0;
         {z1_q, z2_q, vg_q}       <= '0;
         {z1sm_q, z2cm_q, z1sp_q, z2cp_q, c_q} <= '0;
         o_cond <= '0;
      end else begin
         // --------------------------------------
         // stage 1 trig and coordinates
         // --------------------------------------
         sp_q <= sp_c;
         cp_q <= cp_c;
         sm_q <= sm_c;
         cm_q <= cm_c;
         z1_q <= z1_c;
         z2_q <= z2_c;
         vg_q <= ACC'(coef.mu_vg);
         // stage 2 products, floor divide by trig one
         z1sm_q <= (z1_q * ACC'(sm_q)) >>> TSH;
         z2cm_q <= (z2_q * ACC'(cm_q)) >>> TSH;
         z1sp_q <= (z1_q * ACC'(sp_q)) >>> TSH;
         z2cp_q <= (z2_q * ACC'(cp_q)) >>> TSH;
         c_q    <= (vg_q * ACC'(sm_q)) >>> TSH;   // vg sin(theta - phi)
         // stage 3 sign bits
         o_cond[0] <= ~s1[ACC-1];   // S1 >= 0
         o_cond[1] <=  s2[ACC-1];   // S2 < 0
         o_cond[2] <=  s3[ACC-1];   // S3 < 0
         o_cond[3] <=  s2[ACC-1];   // same test, zero_b side
      end
   end

endmodule

//--- hc_debounce.sv
/* per-bit stability filter for the jump conditions */
`timescale 1ns/1ps
`include "hc_consts.svh"

module hc_debounce #(
   parameter int N = 4
) (
   input  logic         i_clock,
   input  logic         i_RESET,
   input  logic [N-1:0] i_cond,
   output logic [N-1:0] o_cond
);

   localparam int CW = $clog2(`HC_DB_LEN + 1);

   logic [CW-1:0] cnt [N];   // cycles input has disagreed

   always_ff @(posedge i_clock or negedge i_RESET) begin
      if (!i_RESET) begin
         o_cond <= '0;
         for (int i = 0; i < N; i++) cnt[i] <= '0;
      end else begin
         for (int i = 0; i < N; i++) begin
            if (i_cond[i] == o_cond[i]) begin
               cnt[i] <= '0;                         // agree, start over
            end else if (cnt[i] == CW'(`HC_DB_LEN - 1)) begin
               o_cond[i] <= i_cond[i];               // stable long enough
               cnt[i]    <= '0;
            end else begin
               cnt[i] <= cnt[i] + 1'b1;
            end
         end
      end
   end

endmodule

//--- hc_switch_fsm.sv
/* four-state switching automaton
   minimum dwell, one or two steps per jump, registered gate decode */
`timescale 1ns/1ps
`include "hc_consts.svh"

module hc_switch_fsm (
   input  logic                   i_clock,
   input  logic                   i_RESET,
   input  logic [3:0]             i_cond,       // debounced c4..c1
   input  logic                   i_run,
   input  logic                   i_phi_zero,   // skip zero states
   output hc_ctrl_pkg::sw_state_e o_state,
   output logic [3:0]             o_mosfet,
   output hc_ctrl_pkg::sigma_t    o_sigma
);

   localparam int DW = $clog2(`HC_MIN_DWELL + 1);

   logic [DW-1:0]          dwell;   // saturates at min dwell
   logic                   dwell_done;
   logic                   jump;
   logic [1:0]             step;
   hc_ctrl_pkg::sw_state_e next_state;

   assign dwell_done = (dwell == DW'(`HC_MIN_DWELL));
   assign jump       = i_run & dwell_done & i_cond[o_state];   // state picks its condition
   assign step       = i_phi_zero ? 2'd2 : 2'd1;
   assign next_state = jump ? hc_ctrl_pkg::sw_state_e'(o_state + step) : o_state;

   // decode from next state so gates move with the state register
   always_ff @(posedge i_clock or negedge i_RESET) begin
      if (!i_RESET) begin
         o_state  <= hc_ctrl_pkg::ST_POS;
         o_mosfet <= hc_ctrl_pkg::MOS_POS;
         o_sigma  <= hc_ctrl_pkg::SIGMA_POS;
         dwell    <= '0;
      end else begin
         o_state  <= next_state;
         o_mosfet <= hc_ctrl_pkg::state_mosfet(next_state);
         o_sigma  <= hc_ctrl_pkg::state_sigma(next_state);
         if (jump) dwell <= '0;                     // restart on each jump
         else if (!dwell_done) dwell <= dwell + 1'b1;
      end
   end

endmodule

//--- hybrid_control.sv
/* hybrid switching controller top level
   axi4-lite config, surface datapath, debounce and automaton */
`timescale 1ns/1ps
`include "hc_consts.svh"

module hybrid_control (
   input  logic                           i_clock,
   input  logic                           i_RESET,
   // axi4-lite slave
   input  logic [`HC_AXI_AW-1:0]          i_awaddr,
   input  logic                           i_awvalid,
   output logic                           o_awready,
   input  logic [`HC_AXI_DW-1:0]          i_wdata,
   input  logic [3:0]                     i_wstrb,
   input  logic                           i_wvalid,
   output logic                           o_wready,
   output logic [1:0]                     o_bresp,
   output logic                           o_bvalid,
   input  logic                           i_bready,
   input  logic [`HC_AXI_AW-1:0]          i_araddr,
   input  logic                           i_arvalid,
   output logic                           o_arready,
   output logic [`HC_AXI_DW-1:0]          o_rdata,
   output logic [1:0]                     o_rresp,
   output logic                           o_rvalid,
   input  logic                           i_rready,
   // power stage
   input  logic signed [`HC_SAMPLE_W-1:0] i_vc,
   input  logic signed [`HC_SAMPLE_W-1:0] i_ic,
   output logic [3:0]                     o_mosfet,
   output logic signed [1:0]              o_sigma
);

   hc_coef_if coef ();

   hc_ctrl_pkg::sw_state_e state;
   logic [3:0]             cond_raw;   // from surfaces
   logic [3:0]             cond_db;    // filtered
   logic                   phi_zero;

   assign phi_zero = (coef.phi == '0);   // two-level switching

   hc_axil_regs u_regs (
      .i_clock   (i_clock),   .i_RESET   (i_RESET),
      .i_awaddr  (i_awaddr),  .i_awvalid (i_awvalid), .o_awready (o_awready),
      .i_wdata   (i_wdata),   .i_wstrb   (i_wstrb),
      .i_wvalid  (i_wvalid),  .o_wready  (o_wready),
      .o_bresp   (o_bresp),   .o_bvalid  (o_bvalid),  .i_bready  (i_bready),
      .i_araddr  (i_araddr),  .i_arvalid (i_arvalid), .o_arready (o_arready),
      .o_rdata   (o_rdata),   .o_rresp   (o_rresp),
      .o_rvalid  (o_rvalid),  .i_rready  (i_rready),
      .i_state   (state),     .coef      (coef.regs)
   );

   hc_jump_eval u_eval (
      .i_clock (i_clock), .i_RESET (i_RESET),
      .i_vc    (i_vc),    .i_ic    (i_ic),
      .i_state (state),   .coef    (coef.eval),
      .o_cond  (cond_raw)
   );

   hc_debounce #(.N(4)) u_db (
      .i_clock (i_clock), .i_RESET (i_RESET),
      .i_cond  (cond_raw), .o_cond (cond_db)
   );

   hc_switch_fsm u_fsm (
      .i_clock    (i_clock),  .i_RESET    (i_RESET),
      .i_cond     (cond_db),  .i_run      (coef.run),
      .i_phi_zero (phi_zero), .o_state    (state),
      .o_mosfet   (o_mosfet), .o_sigma    (o_sigma)
   );

endmodule

//--- hybrid_control_checker.sv
/* bound protocol and gate checks for the hybrid controller */
`timescale 1ns/1ps

module hybrid_control_checker (
   input logic       i_clock,
   input logic       i_RESET,
   input logic [3:0] i_mosfet,
   input logic       i_bvalid,
   input logic       i_bready,
   input logic       i_rvalid,
   input logic       i_rready,
   input logic [1:0] i_state,   // automaton state code
   input logic       i_run
);

   // only the three legal bridge patterns
   a_gate_legal: assert property (@(posedge i_clock) disable iff (!i_RESET)
      i_mosfet inside {4'b1001, 4'b0011, 4'b0110})
      else $error("gate pattern outside the legal set");

   a_bvalid_hold: assert property (@(posedge i_clock) disable iff (!i_RESET)
      (i_bvalid && !i_bready) |=> i_bvalid)
      else $error("write response dropped before bready");

   a_rvalid_hold: assert property (@(posedge i_clock) disable iff (!i_RESET)
      (i_rvalid && !i_rready) |=> i_rvalid)
      else $error("read response dropped before rready");

   // automaton frozen while stopped
   a_state_frozen: assert property (@(posedge i_clock) disable iff (!i_RESET)
      !i_run |=> $stable(i_state))
      else $error("state moved while run was low");

endmodule

//--- hybrid_control_tb.sv
/* testbench for the hybrid controller
   axi config, random held samples, surface reference model and compare */
`timescale 1ns/1ps
`include "hc_consts.svh"

module hybrid_control_tb;

   localparam int TIMEOUT = 200;   // cycles per handshake wait
   localparam int HOLD    = 40;    // cycles a vector is held

   logic        i_clock, i_RESET;
   logic [4:0]  i_awaddr, i_araddr;
   logic        i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready;
   logic [31:0] i_wdata;
   logic [3:0]  i_wstrb;
   logic signed [13:0] i_vc, i_ic;
   logic        o_awready, o_wready, o_bvalid, o_arready, o_rvalid;
   logic [1:0]  o_bresp, o_rresp;
   logic [31:0] o_rdata;
   logic [3:0]  o_mosfet;
   logic signed [1:0] o_sigma;

   int          seed = 32'hfdd3;
   int          cur_state;            // model state
   int          g_theta, g_phi;
   logic [3:0]  exp_mos;
   logic signed [1:0] exp_sig;
   event        check_ev;
   logic [31:0] rd;
   logic [1:0]  resp;
   bit          zero_seen;

   hybrid_control dut0 (.*);

   bind hybrid_control hybrid_control_checker u_chk (
      .i_clock (i_clock), .i_RESET (i_RESET), .i_mosfet (o_mosfet),
      .i_bvalid (o_bvalid), .i_bready (i_bready),
      .i_rvalid (o_rvalid), .i_rready (i_rready),
      .i_state (state), .i_run (coef.run)
   );

   initial begin
      i_clock = 1'b0;
      forever #50 i_clock = ~i_clock;   // 100 ns period
   end

   // global guard
   initial begin
      repeat (400000) @(posedge i_clock);
      $display("ERROR: run did not finish in time");
      stop_with_failure();
   end

   // ----------------------------------------
   // failure reporting
   // ----------------------------------------
   task automatic stop_with_failure();
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_mismatch(input string what);
      $display("MISMATCH at %0t ns: %s", $time, what);
      stop_with_failure();
   endtask

   task automatic report_error(input string what);
      $display("ERROR: %s", what);
      stop_with_failure();
   endtask

   // ----------------------------------------
   // axi4-lite master
   // ----------------------------------------
   task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] r);
      int n;
      @(posedge i_clock);
      i_awaddr  <= addr;
      i_wdata   <= data;
      i_wstrb   <= strb;
      i_awvalid <= 1'b1;
      i_wvalid  <= 1'b1;
      n = 0;
      do begin
         @(negedge i_clock);
         n++;
         if (n > TIMEOUT) report_error("write address never accepted");
      end while (!o_awready);
      @(posedge i_clock);
      i_awvalid <= 1'b0;
      i_wvalid  <= 1'b0;
      n = 0;
      do begin
         @(negedge i_clock);
         n++;
         if (n > TIMEOUT) report_error("write response never came");
      end while (!o_bvalid);
      r = o_bresp;
   endtask

   task automatic axi_read(input logic [4:0] addr, output logic [31:0] data,
                           output logic [1:0] r);
      int n;
      @(posedge i_clock);
      i_araddr  <= addr;
      i_arvalid <= 1'b1;
      n = 0;
      do begin
         @(negedge i_clock);
         n++;
         if (n > TIMEOUT) report_error("read address never accepted");
      end while (!o_arready);
      @(posedge i_clock);
      i_arvalid <= 1'b0;
      n = 0;
      do begin
         @(negedge i_clock);
         n++;
         if (n > TIMEOUT) report_error("read data never came");
      end while (!o_rvalid);
      data = o_rdata;
      r    = o_rresp;
   endtask

   task automatic expect_read(input logic [4:0] addr, input logic [31:0] exp);
      axi_read(addr, rd, resp);
      assert (rd == exp && resp == 2'b00)
         else report_mismatch($sformatf("reg %02h read %08h, want %08h", addr, rd, exp));
   endtask

   // both responses held off, read side still has to get through
   task automatic stall_responses();
      logic [31:0] d;
      logic [1:0]  r;
      int          n;
      @(posedge i_clock);
      i_bready <= 1'b0;
      i_rready <= 1'b0;
      axi_write(5'h10, 32'd45, 4'hf, r);
      axi_read(5'h10, d, r);   // write response still pending
      assert (d == 32'd45 && r == 2'b00)
         else report_mismatch($sformatf("stalled read %08h, want %08h", d, 32'd45));
      repeat (6) @(posedge i_clock);
      @(negedge i_clock);
      assert (o_bvalid && o_rvalid && o_rdata == 32'd45)
         else report_error("response dropped while ready was low");
      @(posedge i_clock);
      i_bready <= 1'b1;
      i_rready <= 1'b1;
      n = 0;
      do begin
         @(negedge i_clock);
         n++;
         if (n > TIMEOUT) report_error("responses not released after ready");
      end while (o_bvalid || o_rvalid);
   endtask

   // ----------------------------------------
   // reference model, exact trig at 90 degree multiples
   // ----------------------------------------
   function automatic longint ref_sin(input int a);
      int r;
      r = ((a % 360) + 360) % 360;
      case (r)
         90:      return 1;
         270:     return -1;
         default: return 0;
      endcase
   endfunction

   function automatic int ref_next_state(input int st, input longint vc, input longint ic,
                                         input longint mu1, input longint mu2,
                                         input longint muvg, input int th, input int ph);
      longint sig, z1, z2, sm, cm, sp, cp, s1, s2, s3;
      bit     c;
      for (int n = 0; n <= 4; n++) begin
         sig = (st == 0) ? 1 : (st == 2) ? -1 : 0;
         z1  = mu1 * vc - sig * muvg;
         z2  = mu2 * ic;
         sm  = ref_sin(th - ph);
         cm  = ref_sin(th - ph + 90);
         sp  = ref_sin(th + ph);
         cp  = ref_sin(th + ph + 90);
         s1  = z1 * sm + z2 * cm + muvg * sm;
         s2  = z1 * sp + z2 * cp;
         s3  = z1 * sm + z2 * cm - muvg * sm;
         case (st)
            0:       c = (s1 >= 0);
            2:       c = (s3 < 0);
            default: c = (s2 < 0);   // both zero states
         endcase
         if (!c) return st;
         if (n == 4) return -1;       // never settles
         st = (st + ((ph == 0) ? 2 : 1)) % 4;
      end
      return -1;
   endfunction

   function automatic int model(input logic signed [13:0] vc, input logic signed [13:0] ic);
      return ref_next_state(cur_state, vc, ic, `HC_MU_Z1_RST, `HC_MU_Z2_RST,
                            `HC_MU_VG_RST, g_theta, g_phi);
   endfunction

   // compare process
   always @(check_ev) begin
      assert (o_mosfet == exp_mos && o_sigma == exp_sig)
         else report_mismatch($sformatf("gates %b sigma %0d, want %b %0d",
                                        o_mosfet, o_sigma, exp_mos, exp_sig));
   end

   task automatic compare_state(input int st);
      @(negedge i_clock);
      exp_mos = (st == 0) ? 4'b1001 : (st == 2) ? 4'b0110 : 4'b0011;
      exp_sig = (st == 0) ? 2'sd1 : (st == 2) ? -2'sd1 : 2'sd0;
      -> check_ev;
      @(posedge i_clock);
   endtask

   task automatic pick_vector(output logic signed [13:0] vc,
                              output logic signed [13:0] ic, output int nxt);
      int tries;
      tries = 0;
      do begin
         vc  = 14'($random(seed));
         ic  = 14'($random(seed));
         nxt = model(vc, ic);
         tries++;
         if (tries > 100) report_error("no settling vector found");
      end while (nxt < 0);   // discard unsettled ones
   endtask

   // stop, load samples, flush pipeline, then release the automaton
   task automatic run_vector();
      logic signed [13:0] vc, ic;
      int nxt;
      pick_vector(vc, ic, nxt);
      axi_write(5'h00, 32'd0, 4'hf, resp);
      @(posedge i_clock);
      i_vc <= vc;
      i_ic <= ic;
      repeat (10) @(posedge i_clock);
      axi_write(5'h00, 32'd1, 4'hf, resp);
      repeat (HOLD) @(posedge i_clock);
      compare_state(nxt);
      cur_state = nxt;
      if (nxt == 1 || nxt == 3) zero_seen = 1'b1;
   endtask

   task automatic set_angles(input int th, input int ph);
      g_theta = th;
      g_phi   = ph;
      axi_write(5'h00, 32'd0, 4'hf, resp);
      axi_write(5'h10, th, 4'hf, resp);
      axi_write(5'h14, ph, 4'hf, resp);
   endtask

   initial begin
      logic signed [13:0] gvc, gic, hvc, hic;
      int nxt;
      i_RESET = 1'b0;
      {i_awaddr, i_araddr, i_wdata, i_wstrb} = '0;
      {i_awvalid, i_wvalid, i_arvalid} = '0;
      i_bready = 1'b1;
      i_rready = 1'b1;
      i_vc = '0;
      i_ic = '0;
      cur_state = 0;
      g_theta = 0;
      g_phi = 0;
      zero_seen = 1'b0;
      repeat (3) @(posedge i_clock);
      i_RESET <= 1'b1;

      // reset values
      expect_read(5'h00, 32'd0);
      expect_read(5'h04, `HC_MU_Z1_RST);
      expect_read(5'h08, `HC_MU_Z2_RST);
      expect_read(5'h0C, `HC_MU_VG_RST);
      expect_read(5'h10, 32'd0);
      expect_read(5'h14, 32'd0);
      expect_read(5'h18, 32'h4);   // sigma +1, ST_POS
      compare_state(0);

      // write, byte strobes, unmapped
      axi_write(5'h04, 32'haabbccdd, 4'hf, resp);
      assert (resp == 2'b00) else report_mismatch("mapped write not OKAY");
      axi_write(5'h04, 32'h11223344, 4'b0101, resp);
      expect_read(5'h04, 32'haa22cc44);
      axi_write(5'h08, 32'h12345678, 4'b1000, resp);
      expect_read(5'h08, 32'h1200005a);
      axi_write(5'h0C, 32'h0000abcd, 4'b0011, resp);
      expect_read(5'h0C, (`HC_MU_VG_RST & 32'hffff0000) | 32'habcd);
      axi_write(5'h10, 32'hffffff5a, 4'b0001, resp);
      expect_read(5'h10, 32'h5a);
      axi_write(5'h14, 32'd270, 4'hf, resp);
      expect_read(5'h14, 32'd270);
      axi_write(5'h1C, 32'h1, 4'hf, resp);
      assert (resp == 2'b10) else report_mismatch("unmapped write not SLVERR");
      axi_read(5'h1C, rd, resp);
      assert (resp == 2'b10) else report_mismatch("unmapped read not SLVERR");
      stall_responses();
      axi_write(5'h04, `HC_MU_Z1_RST, 4'hf, resp);
      axi_write(5'h08, `HC_MU_Z2_RST, 4'hf, resp);
      axi_write(5'h0C, `HC_MU_VG_RST, 4'hf, resp);
      set_angles(0, 0);

      // stopped automaton ignores samples
      for (int i = 0; i < 8; i++) begin
         @(posedge i_clock);
         i_vc <= 14'($random(seed));
         i_ic <= 14'($random(seed));
         repeat (20) @(posedge i_clock);
         compare_state(0);
      end

      // two-level switching, theta sweep
      for (int t = 0; t < 4; t++) begin
         set_angles(90 * t, 0);
         for (int i = 0; i < 6; i++) begin
            run_vector();
            assert (o_sigma != 2'sd0) else report_mismatch("zero state with phi 0");
         end
      end

      // three-level switching
      set_angles(0, 90);
      for (int i = 0; i < 30; i++) run_vector();
      assert (zero_seen) else report_error("zero states never reached with phi 90");

      // short glitch must not switch, held vector must
      hvc = i_vc;
      hic = i_ic;
      do begin
         pick_vector(gvc, gic, nxt);
      end while (nxt == cur_state);
      @(posedge i_clock);
      i_vc <= gvc;
      i_ic <= gic;
      repeat (`HC_DB_LEN - 1) @(posedge i_clock);
      i_vc <= hvc;
      i_ic <= hic;
      repeat (20) @(posedge i_clock);
      compare_state(cur_state);
      i_vc <= gvc;
      i_ic <= gic;
      repeat (HOLD) @(posedge i_clock);
      compare_state(nxt);

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

//--- hybrid_control.f
+incdir+.
hc_ctrl_pkg.sv
hc_regs_pkg.sv
hc_coef_if.sv
hc_trig_lut.sv
hc_axil_regs.sv
hc_jump_eval.sv
hc_debounce.sv
hc_switch_fsm.sv
hybrid_control.sv
hybrid_control_checker.sv
hybrid_control_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= hybrid_control_tb
FLIST     ?= hybrid_control.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
